// ==== sources.f ====
hdl/lcd_pkg.sv
hdl/lcd_host_regs.sv
hdl/lcd_boot_seq.sv
hdl/lcd_job_arbiter.sv
hdl/lcd_link_writer.sv
hdl/lcd_ctrl_top.sv
verification/tb_clkgen.sv
verification/lcd_ctrl_sva.sv
verification/lcd_ctrl_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the testbench with Verilator, run it and look for the pass line

cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f sources.f --top-module lcd_ctrl_tb \
    --Mdir obj_dir -o lcd_sim &&
./obj_dir/lcd_sim | tee /dev/stderr | grep -q "^TEST PASS$" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

// ==== verification/lcd_ctrl_tb.sv ====
// lcd_ctrl_tb
// drives the controller over AXI4-Lite, records panel bytes at each wrx
// strobe and compares them against a byte list built from the opcode table
`timescale 1ns/1ps
`default_nettype none

module lcd_ctrl_tb;

    localparam int pause_len     = 20;
    localparam int n_random      = 6;
    localparam int n_jobs        = 4 + 4 + n_random + 1 + 2;
    localparam int n_pauses      = 3;   // swreset, sleep_out, sleep_in
    localparam int timeout_cycles = n_jobs * 200 + n_pauses * pause_len + 10;

    typedef logic [8:0] byte_list_t [$];   // {dcx, data}

    logic        clk, nrst;
    logic [3:0]  awaddr, araddr;
    logic        awvalid, awready, wvalid, wready, bvalid, bready;
    logic        arvalid, arready, rvalid, rready;
    logic [31:0] wdata, rdata;
    logic [3:0]  wstrb;
    logic [1:0]  bresp, rresp;
    logic [7:0]  data;
    logic        csx, dcx, wrx, rdx, busy;
    logic [8:0]  exp_q [$];
    logic [8:0]  obs_q [$];
    logic [8:0]  got_byte;
    logic [31:0] rng = 32'hd052_74e8;

    tb_clkgen #(.period(100)) u_clk (.clk);

    lcd_ctrl_top #(.pause_cycles(24'(pause_len))) UUT (
        .clk, .nrst, .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid,
        .wready, .bresp, .bvalid, .bready, .araddr, .arvalid, .arready,
        .rdata, .rresp, .rvalid, .rready, .data, .csx, .dcx, .wrx, .rdx, .busy
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic is_table_op(input logic [7:0] op);
        return op inside {8'h00, 8'h01, 8'h10, 8'h11, 8'h28, 8'h29,
                          8'h2A, 8'h2B, 8'h2C, 8'h2E, 8'h36, 8'h3A};
    endfunction

    function automatic int ref_count(input logic [7:0] op, input logic [3:0] cnt);
        case (op)
            8'h2A, 8'h2B: return 4;   // caset, paset
            8'h2C, 8'h2E: return 2;   // ramwr, ramrd
            8'h36, 8'h3A: return 1;   // madctl, colmod
            8'h00, 8'h01, 8'h10, 8'h11, 8'h28, 8'h29: return 0;
            default:      return (cnt > 4'd4) ? 4 : int'(cnt);
        endcase
    endfunction

    function automatic byte_list_t expected_bytes(input logic [31:0] desc,
                                                  input logic [31:0] param);
        byte_list_t lst;
        int         n;
        n = ref_count(desc[7:0], desc[11:8]);
        lst.push_back({1'b0, desc[7:0]});
        for (int i = 0; i < n; i++) begin
            lst.push_back({1'b1, param[31 - 8*i -: 8]});   // msb byte first
        end
        return lst;
    endfunction

    task automatic stop_with_fail(input string reason);
        $display("%s", reason);
        $display("TEST FAIL");
        $fatal(1);
    endtask

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                               input string msg);
        if (got !== exp) begin
            stop_with_fail($sformatf("mismatch at %0t ns: %s, got %0h expected %0h",
                                     $time, msg, got, exp));
        end
    endtask

    task automatic expect_job(input logic [31:0] desc, input logic [31:0] param);
        byte_list_t lst;
        lst = expected_bytes(desc, param);
        foreach (lst[i]) exp_q.push_back(lst[i]);
    endtask

    task automatic axi_write(input logic [3:0] addr, input logic [31:0] val);
        @(negedge clk);
        awaddr  = addr;
        wdata   = val;
        wstrb   = 4'hF;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        #1;
        while (!(awready && wready)) begin   // held off while a job is pending
            @(negedge clk);
            #1;
        end
        @(negedge clk);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        while (!bvalid) @(negedge clk);
        check_value(32'(bresp), 32'd0, "write response");
    endtask

    task automatic axi_read(input logic [3:0] addr, output logic [31:0] val);
        @(negedge clk);
        araddr  = addr;
        arvalid = 1'b1;
        #1;
        while (!arready) begin
            @(negedge clk);
            #1;
        end
        @(negedge clk);
        arvalid = 1'b0;
        while (!rvalid) @(negedge clk);
        check_value(32'(rresp), 32'd0, "read response");
        val = rdata;
    endtask

    // all expected bytes seen and the writer back in idle
    task automatic wait_idle();
        while (exp_q.size() != 0 || obs_q.size() != 0 || busy) @(negedge clk);
    endtask

    task automatic run_job(input logic [31:0] desc, input logic [31:0] param);
        expect_job(desc, param);
        axi_write(4'h0, desc);
        axi_write(4'h4, param);
        wait_idle();
    endtask

    always @(negedge clk) begin
        if (nrst && wrx) obs_q.push_back({dcx, data});   // panel bus monitor
        check_value(32'(rdx), 32'd1, "rdx held inactive");
    end

    always @(posedge clk) begin
        while (obs_q.size() != 0) begin
            got_byte = obs_q.pop_front();
            if (exp_q.size() == 0) begin
                stop_with_fail($sformatf("unexpected byte %0h on the panel bus at %0t ns",
                                         got_byte, $time));
            end else begin
                check_value(32'(got_byte), 32'(exp_q.pop_front()), "panel byte {dcx,data}");
            end
        end
    end

    initial begin
        repeat (timeout_cycles) @(posedge clk);
        stop_with_fail("timeout: the controller did not finish its jobs in time");
    end

    initial begin
        logic [31:0] st;
        logic [31:0] desc;
        logic [31:0] param;
        logic [7:0]  op;
        logic [7:0]  table_ops [4];
        int          cnt;
        table_ops = '{8'h2A, 8'h2C, 8'h36, 8'h28};
        nrst = 1'b0;
        awaddr = '0;
        awvalid = 1'b0;
        wdata = '0;
        wstrb = '0;
        wvalid = 1'b0;
        bready = 1'b1;
        araddr = '0;
        arvalid = 1'b0;
        rready = 1'b1;
        expect_job(32'h01, 32'h0);   // boot list
        expect_job(32'h11, 32'h0);
        expect_job(32'h3A, 32'h5500_0000);
        expect_job(32'h29, 32'h0);
        repeat (10) @(negedge clk);
        nrst = 1'b1;
        wait_idle();
        axi_read(4'h8, st);
        check_value(32'(st[1]), 32'd1, "boot_done after boot list");
        foreach (table_ops[i]) begin
            rng = lcg_next(rng);
            desc = {20'h0, rng[3:0], table_ops[i]};   // count field is ignored
            rng = lcg_next(rng);
            run_job(desc, rng);
        end
        for (int k = 0; k < n_random; k++) begin
            rng = lcg_next(rng);
            op = rng[23:16];
            while (is_table_op(op)) begin
                rng = lcg_next(rng);
                op = rng[23:16];
            end
            desc = {12'h0, rng[31:24], rng[11:8], op};
            rng = lcg_next(rng);
            run_job(desc, rng);
        end
        expect_job(32'h10, 32'h0);   // sleep_in with its pause
        axi_write(4'h0, 32'h10);
        axi_write(4'h4, 32'h0);
        while (!wrx) @(negedge clk);
        cnt = 0;
        @(negedge clk);
        while (busy) begin
            check_value(32'(wrx), 32'd0, "strobe during pause");
            cnt++;
            @(negedge clk);
        end
        check_value(32'(cnt >= pause_len), 32'd1, "busy length after sleep_in");
        wait_idle();
        desc = 32'h2A;
        rng = lcg_next(rng);
        param = rng;
        expect_job(desc, param);
        axi_write(4'h0, desc);
        axi_write(4'h4, param);
        while (!busy) @(negedge clk);
        axi_read(4'h8, st);
        check_value(st & 32'h7, 32'h7, "status during host job");
        rng = lcg_next(rng);
        expect_job(desc, rng);
        axi_write(4'h4, rng);   // stalls until the first job is done
        check_value(32'(exp_q.size()), 32'd5, "bytes left when second job launched");
        wait_idle();
        $display("TEST PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verification/lcd_ctrl_sva.sv ====
// lcd_ctrl_sva
// panel bus protocol properties, bound to the link writer
`timescale 1ns/1ps
`default_nettype none

module lcd_ctrl_sva (
    input logic       clk,
    input logic       nrst,
    input logic [7:0] data,
    input logic       csx,
    input logic       dcx,
    input logic       wrx
);

    strobe_single: assert property (@(posedge clk) disable iff (!nrst) wrx |=> !wrx)
        else $error("wrx stayed high for more than one cycle");

    strobe_selected: assert property (@(posedge clk) disable iff (!nrst) wrx |-> !csx)
        else $error("wrx high while csx is high");

    // byte and dcx must already be settled when the strobe is seen
    strobe_stable: assert property (@(posedge clk) disable iff (!nrst)
        wrx |-> $stable(data) && $stable(dcx))
        else $error("data or dcx moved around the wrx strobe");

endmodule

bind lcd_link_writer lcd_ctrl_sva u_sva (
    .clk(clk),
    .nrst(nrst),
    .data(data),
    .csx(csx),
    .dcx(dcx),
    .wrx(wrx)
);

`default_nettype wire

// ==== verification/tb_clkgen.sv ====
// tb_clkgen
// free-running testbench clock
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen #(
    parameter int period = 100
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;   // 50 ns high, 50 ns low
    end

endmodule

`default_nettype wire

// ==== hdl/lcd_ctrl_top.sv ====
// lcd_ctrl_top
// TFT parallel-bus controller: AXI4-Lite registers and boot sequencer
// share one panel link writer through a fixed-priority arbiter
`timescale 1ns/1ps
`default_nettype none

module lcd_ctrl_top #(
    parameter logic [23:0] pause_cycles = 24'd1200000
) (
    input  logic        clk,
    input  logic        nrst,
    input  logic [3:0]  awaddr,
    input  logic        awvalid,
    output logic        awready,
    input  logic [31:0] wdata,
    input  logic [3:0]  wstrb,
    input  logic        wvalid,
    output logic        wready,
    output logic [1:0]  bresp,
    output logic        bvalid,
    input  logic        bready,
    input  logic [3:0]  araddr,
    input  logic        arvalid,
    output logic        arready,
    output logic [31:0] rdata,
    output logic [1:0]  rresp,
    output logic        rvalid,
    input  logic        rready,
    output logic [7:0]  data,
    output logic        csx,
    output logic        dcx,
    output logic        wrx,
    output logic        rdx,
    output logic        busy
);

    logic        host_req, host_ack, boot_req, boot_ack, boot_done;
    logic [31:0] host_desc, host_param, boot_desc, boot_param;
    logic        start, link_done;
    logic [31:0] job_desc, job_param;

    lcd_host_regs u_regs (
        .clk, .nrst, .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid,
        .wready, .bresp, .bvalid, .bready, .araddr, .arvalid, .arready,
        .rdata, .rresp, .rvalid, .rready, .host_req, .host_desc, .host_param,
        .host_done(host_ack), .busy, .boot_done
    );

    lcd_boot_seq u_boot (
        .clk, .nrst, .boot_req, .boot_desc, .boot_param,
        .boot_done_ack(boot_ack), .boot_done
    );

    lcd_job_arbiter u_arb (
        .clk, .nrst, .boot_req, .boot_desc, .boot_param, .boot_ack,
        .host_req, .host_desc, .host_param, .host_ack, .start, .job_desc,
        .job_param, .link_done, .busy
    );

    lcd_link_writer #(.pause_cycles(pause_cycles)) u_writer (
        .clk, .nrst, .start, .job_desc, .job_param, .done(link_done), .busy,
        .data, .csx, .dcx, .wrx, .rdx
    );

endmodule

`default_nettype wire

// ==== hdl/lcd_link_writer.sv ====
// lcd_link_writer
// sends one job to the panel: command byte with dcx low, then parameter
// bytes msb first with dcx high, one wrx strobe per byte.
// reset and sleep commands get a long pause before the finish cycle
`timescale 1ns/1ps
`default_nettype none

module lcd_link_writer import lcd_pkg::*; #(
    parameter logic [23:0] pause_cycles = 24'd1200000
) (
    input  logic        clk,
    input  logic        nrst,
    input  logic        start,
    input  logic [31:0] job_desc,
    input  logic [31:0] job_param,
    output logic        done,
    output logic        busy,
    output logic [7:0]  data,
    output logic        csx,
    output logic        dcx,
    output logic        wrx,
    output logic        rdx
);

    localparam logic [2:0] st_idle   = 3'd0;
    localparam logic [2:0] st_load   = 3'd1;
    localparam logic [2:0] st_settle = 3'd2;
    localparam logic [2:0] st_strobe = 3'd3;
    localparam logic [2:0] st_pause  = 3'd4;
    localparam logic [2:0] st_finish = 3'd5;

    logic [2:0]  state;
    logic [2:0]  remain;     // parameter bytes still to go
    logic [1:0]  byte_idx;   // next parameter byte
    logic        pause_q;
    logic [23:0] timer;
    lcd_word_u   desc_in;
    lcd_word_u   param_q;

    assign desc_in = job_desc;
    assign rdx     = 1'b1;   // reads not supported

    always_ff @(posedge clk) begin
        if (state == st_idle && start) param_q <= job_param;
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            state    <= st_idle;
            remain   <= '0;
            byte_idx <= '0;
            pause_q  <= 1'b0;
            timer    <= '0;
            done     <= 1'b0;
            busy     <= 1'b0;
            data     <= '0;
            csx      <= 1'b1;
            dcx      <= 1'b0;
            wrx      <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                st_idle: begin
                    if (start) begin
                        data     <= desc_in.desc.opcode;   // command byte first
                        dcx      <= 1'b0;
                        csx      <= 1'b0;
                        busy     <= 1'b1;
                        remain   <= param_count(desc_in.desc.opcode, desc_in.desc.count);
                        pause_q  <= needs_pause(desc_in.desc.opcode);
                        byte_idx <= 2'd3;
                        state    <= st_load;
                    end
                end
                st_load: state <= st_settle;
                st_settle: begin
                    wrx   <= 1'b1;
                    state <= st_strobe;
                end
                st_strobe: begin
                    wrx <= 1'b0;
                    if (remain != 3'd0) begin
                        data     <= param_q.params[byte_idx];
                        dcx      <= 1'b1;
                        byte_idx <= byte_idx - 1'b1;
                        remain   <= remain - 1'b1;
                        state    <= st_load;
                    end else if (pause_q) begin
                        csx   <= 1'b1;    // release the panel during the wait
                        timer <= '0;
                        state <= st_pause;
                    end else begin
                        csx   <= 1'b1;
                        done  <= 1'b1;
                        state <= st_finish;
                    end
                end
                st_pause: begin
                    if (timer == pause_cycles - 24'd1) begin
                        done  <= 1'b1;
                        state <= st_finish;
                    end else begin
                        timer <= timer + 24'd1;
                    end
                end
                st_finish: begin
                    busy  <= 1'b0;
                    dcx   <= 1'b0;
                    state <= st_idle;
                end
                default: state <= st_idle;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hdl/lcd_job_arbiter.sv ====
// lcd_job_arbiter
// fixed priority between boot sequencer and host, one job in flight
`timescale 1ns/1ps
`default_nettype none

module lcd_job_arbiter (
    input  logic        clk,
    input  logic        nrst,
    input  logic        boot_req,
    input  logic [31:0] boot_desc,
    input  logic [31:0] boot_param,
    output logic        boot_ack,
    input  logic        host_req,
    input  logic [31:0] host_desc,
    input  logic [31:0] host_param,
    output logic        host_ack,
    output logic        start,
    output logic [31:0] job_desc,
    output logic [31:0] job_param,
    input  logic        link_done,
    input  logic        busy
);

    logic active;       // job handed to the writer, waiting for done
    logic owner_boot;   // who owns the job in flight
    logic grant;

    assign grant    = !active && !busy && (boot_req || host_req);
    assign boot_ack = link_done && active && owner_boot;
    assign host_ack = link_done && active && !owner_boot;

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            active     <= 1'b0;
            owner_boot <= 1'b0;
            start      <= 1'b0;
        end else begin
            start <= grant;
            if (grant) begin
                active     <= 1'b1;
                owner_boot <= boot_req;   // boot wins a tie
            end else if (link_done) begin
                active <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (grant) begin
            job_desc  <= boot_req ? boot_desc  : host_desc;
            job_param <= boot_req ? boot_param : host_param;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/lcd_boot_seq.sv ====
// lcd_boot_seq
// walks the boot table once after reset, one job request per entry
`timescale 1ns/1ps
`default_nettype none

module lcd_boot_seq import lcd_pkg::*; (
    input  logic        clk,
    input  logic        nrst,
    output logic        boot_req,
    output logic [31:0] boot_desc,
    output logic [31:0] boot_param,
    input  logic        boot_done_ack,
    output logic        boot_done
);

    localparam int idx_w = $clog2(boot_len);

    logic [idx_w-1:0] idx;
    lcd_word_u        entry;

    assign entry      = boot_table[idx][63:32];
    assign boot_desc  = entry;
    assign boot_param = boot_table[idx][31:0];
    assign boot_req   = !boot_done;

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            idx       <= '0;
            boot_done <= 1'b0;
        end else if (!boot_done && boot_done_ack) begin
            if (idx == idx_w'(boot_len - 1)) begin
                boot_done <= 1'b1;    // last entry sent
            end else begin
                idx <= idx + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/lcd_host_regs.sv ====
// lcd_host_regs
// AXI4-Lite register port: descriptor, parameter word and status.
// a write to the parameter word launches a host job
`timescale 1ns/1ps
`default_nettype none

module lcd_host_regs import lcd_pkg::*; (
    input  logic        clk,
    input  logic        nrst,
    input  logic [3:0]  awaddr,
    input  logic        awvalid,
    output logic        awready,
    input  logic [31:0] wdata,
    input  logic [3:0]  wstrb,
    input  logic        wvalid,
    output logic        wready,
    output logic [1:0]  bresp,
    output logic        bvalid,
    input  logic        bready,
    input  logic [3:0]  araddr,
    input  logic        arvalid,
    output logic        arready,
    output logic [31:0] rdata,
    output logic [1:0]  rresp,
    output logic        rvalid,
    input  logic        rready,
    output logic        host_req,
    output logic [31:0] host_desc,
    output logic [31:0] host_param,
    input  logic        host_done,
    input  logic        busy,
    input  logic        boot_done
);

    logic [31:0] desc_q;
    logic [31:0] param_q;
    logic        wr_go;
    logic        rd_go;
    lcd_word_u   desc_view;

    function automatic logic [31:0] merge(input logic [31:0] old,
                                          input logic [31:0] din,
                                          input logic [3:0]  strb);
        logic [31:0] res;
        res = old;
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) res[8*i +: 8] = din[8*i +: 8];
        end
        return res;
    endfunction

    // address and data taken together, held off while a job is pending
    assign wr_go   = awvalid && wvalid && !bvalid && !host_req;
    assign awready = wr_go;
    assign wready  = wr_go;
    assign bresp   = 2'b00;

    assign rd_go   = arvalid && !rvalid;
    assign arready = rd_go;
    assign rresp   = 2'b00;

    assign desc_view  = desc_q;
    assign host_desc  = desc_q;
    assign host_param = param_q;

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            bvalid   <= 1'b0;
            rvalid   <= 1'b0;
            host_req <= 1'b0;
        end else begin
            if (wr_go) bvalid <= 1'b1;
            else if (bready) bvalid <= 1'b0;
            if (rd_go) rvalid <= 1'b1;
            else if (rready) rvalid <= 1'b0;
            if (wr_go && awaddr == 4'h4) host_req <= 1'b1;   // launch
            else if (host_done) host_req <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_go && awaddr == 4'h0) desc_q <= merge(desc_q, wdata, wstrb);
        if (wr_go && awaddr == 4'h4) param_q <= merge(param_q, wdata, wstrb);
        if (rd_go) begin
            case (araddr)
                4'h0:    rdata <= {20'h0, desc_view.desc.count, desc_view.desc.opcode};
                4'h8:    rdata <= {29'h0, host_req, boot_done, busy};   // status
                default: rdata <= 32'h0;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hdl/lcd_pkg.sv ====
// lcd_pkg
// shared definitions for the TFT parallel-bus controller: the descriptor
// word views, panel opcodes, per-opcode parameter counts and the boot list
`default_nettype none

package lcd_pkg;

    // one 32-bit job word, read either as a descriptor or as parameter bytes
    typedef union packed {
        struct packed {
            logic [19:0] unused;
            logic [3:0]  count;    // byte count for opcodes not in the table
            logic [7:0]  opcode;
        } desc;
        logic [3:0][7:0] params;   // byte 3 goes out first
    } lcd_word_u;

    // a job (lcd_job_t) is carried as a descriptor word plus a parameter word

    localparam logic [7:0] op_nop       = 8'h00;
    localparam logic [7:0] op_swreset   = 8'h01;
    localparam logic [7:0] op_sleep_in  = 8'h10;
    localparam logic [7:0] op_sleep_out = 8'h11;
    localparam logic [7:0] op_disp_off  = 8'h28;
    localparam logic [7:0] op_disp_on   = 8'h29;
    localparam logic [7:0] op_caset     = 8'h2A;
    localparam logic [7:0] op_paset     = 8'h2B;
    localparam logic [7:0] op_ramwr     = 8'h2C;
    localparam logic [7:0] op_ramrd     = 8'h2E;   // sent as a plain write
    localparam logic [7:0] op_madctl    = 8'h36;
    localparam logic [7:0] op_colmod    = 8'h3A;

    function automatic logic [2:0] param_count(input logic [7:0] opcode,
                                               input logic [3:0] count);
        case (opcode)
            op_caset, op_paset:   return 3'd4;
            op_ramwr, op_ramrd:   return 3'd2;
            op_colmod, op_madctl: return 3'd1;
            op_swreset, op_sleep_in, op_sleep_out,
            op_disp_on, op_disp_off, op_nop: return 3'd0;
            default:              return (count > 4'd4) ? 3'd4 : count[2:0];
        endcase
    endfunction

    // panel needs a long settle time after these
    function automatic logic needs_pause(input logic [7:0] opcode);
        return (opcode == op_swreset) || (opcode == op_sleep_in) ||
               (opcode == op_sleep_out);
    endfunction

    localparam int boot_len = 4;

    // {descriptor, parameter} per entry
    localparam logic [63:0] boot_table [boot_len] = '{
        {24'h0, op_swreset,   32'h0},
        {24'h0, op_sleep_out, 32'h0},
        {24'h0, op_colmod,    8'h55, 24'h0},   // 16 bit per pixel
        {24'h0, op_disp_on,   32'h0}
    };

endpackage

`default_nettype wire
